// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP      ?= tb_cpu
FILELIST ?= project.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [3:0] mask_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        TRAP_NONE             = 2'd0,
        TRAP_ILLEGAL          = 2'd1,
        TRAP_MISALIGNED_LS    = 2'd2,
        TRAP_MISALIGNED_FETCH = 2'd3
    } trap_cause_e;

    // --------------------------------------------------
    // Instruction formats, listed from bit 31 down.
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

    localparam word_t EBREAK_WORD = 32'h0010_0073;

endpackage

// ==== common/dmem_if.sv ====
`timescale 1ns/100ps

interface dmem_if;

    cpu_pkg::word_t addr;
    cpu_pkg::word_t wdata;
    cpu_pkg::mask_t mask;
    logic           r_en;
    logic           w_en;
    cpu_pkg::word_t rdata;

    modport core (
        output addr, wdata, mask, r_en, w_en,
        input  rdata
    );

    modport mem (
        input  addr, wdata, mask, r_en, w_en,
        output rdata
    );

endinterface

// ==== core/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   y,
    output logic             equal
);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:    y = a + b;
            cpu_pkg::ALU_SUB:    y = a - b;
            cpu_pkg::ALU_AND:    y = a & b;
            cpu_pkg::ALU_OR:     y = a | b;
            cpu_pkg::ALU_XOR:    y = a ^ b;
            cpu_pkg::ALU_PASS_B: y = b;
            default:             y = a + b;
        endcase
    end

    // Branches compare the two register operands directly.
    assign equal = (a == b);

endmodule

// ==== core/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    input  cpu_pkg::word_t       fetch_data,
    output cpu_pkg::word_t       fetch_addr,
    output logic                 fetch_en,
    output logic                 halted,
    output logic                 trap,
    output cpu_pkg::trap_cause_e trap_cause,
    output cpu_pkg::word_t       trap_pc,
    output cpu_pkg::word_t       result,
    dmem_if.core                 dmem
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_FETCH = 3'd1;
    localparam logic [2:0] S_EXEC  = 3'd2;
    localparam logic [2:0] S_WB    = 3'd3;
    localparam logic [2:0] S_HALT  = 3'd4;

    logic [2:0]           state;
    logic                 run_q;
    cpu_pkg::word_t       pc;
    cpu_pkg::inst_t       inst_q;
    cpu_pkg::inst_t       inst;

    cpu_pkg::alu_op_e     alu_op;
    cpu_pkg::word_t       imm;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
    logic                 use_imm;
    logic                 reg_we;
    logic                 is_load;
    logic                 is_store;
    cpu_pkg::mask_t       store_mask;
    logic                 is_branch;
    logic                 branch_ne;
    logic                 is_jal;
    logic                 is_ebreak;
    logic                 illegal;

    cpu_pkg::word_t       rf_rdata1;
    cpu_pkg::word_t       rf_rdata2;
    cpu_pkg::word_t       rf_wdata;
    logic                 rf_we;
    cpu_pkg::word_t       alu_y;
    logic                 alu_equal;

    cpu_pkg::word_t       pc_plus4;
    cpu_pkg::word_t       next_pc;
    logic                 br_taken;
    logic                 ls_misaligned;
    logic                 tgt_misaligned;
    cpu_pkg::trap_cause_e cause_now;
    logic                 exec_go;

    // The fetched word is decoded straight off the memory in EXEC. WB
    // still needs rd, so the instruction is also kept.
    assign inst = (state == S_EXEC) ? cpu_pkg::inst_t'(fetch_data) : inst_q;

    inst_decoder u_decoder (
        .inst      (inst),
        .alu_op    (alu_op),
        .imm       (imm),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .use_imm   (use_imm),
        .reg_we    (reg_we),
        .is_load   (is_load),
        .is_store  (is_store),
        .store_mask(store_mask),
        .is_branch (is_branch),
        .branch_ne (branch_ne),
        .is_jal    (is_jal),
        .is_ebreak (is_ebreak),
        .illegal   (illegal)
    );

    reg_file u_reg_file (
        .clk   (clk),
        .rst   (rst),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .we    (rf_we),
        .wdata (rf_wdata),
        .rdata1(rf_rdata1),
        .rdata2(rf_rdata2)
    );

    alu u_alu (
        .op   (alu_op),
        .a    (rf_rdata1),
        .b    (use_imm ? imm : rf_rdata2),
        .y    (alu_y),
        .equal(alu_equal)
    );

    // --------------------------------------------------
    // Next pc and trap detection
    // --------------------------------------------------
    assign pc_plus4 = pc + 32'd4;
    assign br_taken = is_branch && (alu_equal ^ branch_ne);
    assign next_pc  = (br_taken || is_jal) ? pc + imm : pc_plus4;

    // pc itself is always aligned, so bit 1 of the offset decides.
    assign tgt_misaligned = (br_taken && inst.b.imm_4_1[0]) || (is_jal && inst.j.imm_10_1[0]);
    assign ls_misaligned  = (is_load || (is_store && &store_mask)) && (alu_y[1:0] != 2'b00);

    always_comb begin
        if (illegal) begin
            cause_now = cpu_pkg::TRAP_ILLEGAL;
        end else if (ls_misaligned) begin
            cause_now = cpu_pkg::TRAP_MISALIGNED_LS;
        end else if (tgt_misaligned) begin
            cause_now = cpu_pkg::TRAP_MISALIGNED_FETCH;
        end else begin
            cause_now = cpu_pkg::TRAP_NONE;
        end
    end

    assign exec_go = (state == S_EXEC) && run && (cause_now == cpu_pkg::TRAP_NONE) && !is_ebreak;

    // --------------------------------------------------
    // Memory ports and writeback
    // --------------------------------------------------
    assign fetch_addr = pc;
    assign fetch_en   = (state == S_FETCH) && run;

    assign dmem.addr  = alu_y;
    assign dmem.mask  = cpu_pkg::mask_t'(store_mask << alu_y[1:0]);
    assign dmem.wdata = (&store_mask) ? rf_rdata2 : {4{rf_rdata2[7:0]}};
    assign dmem.r_en  = exec_go && is_load;
    assign dmem.w_en  = exec_go && is_store;

    assign rf_we    = (exec_go && reg_we && !is_load) || ((state == S_WB) && run);
    assign rf_wdata = (state == S_WB) ? dmem.rdata : (is_jal ? pc_plus4 : alu_y);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            run_q      <= 1'b0;
            pc         <= '0;
            halted     <= 1'b0;
            trap       <= 1'b0;
            trap_cause <= cpu_pkg::TRAP_NONE;
        end else begin
            run_q <= run;
            if (!run) begin
                state <= S_IDLE;
            end else begin
                case (state)
                    S_IDLE: begin
                        if (!run_q) begin
                            state      <= S_FETCH;
                            pc         <= '0;
                            halted     <= 1'b0;
                            trap       <= 1'b0;
                            trap_cause <= cpu_pkg::TRAP_NONE;
                        end
                    end
                    S_FETCH: state <= S_EXEC;
                    S_EXEC: begin
                        if (cause_now != cpu_pkg::TRAP_NONE) begin
                            trap       <= 1'b1;
                            trap_cause <= cause_now;
                            state      <= S_HALT;
                        end else if (is_ebreak) begin
                            halted <= 1'b1;
                            state  <= S_HALT;
                        end else begin
                            pc    <= next_pc;
                            state <= is_load ? S_WB : S_FETCH;
                        end
                    end
                    S_WB:    state <= S_FETCH;
                    default: state <= S_HALT;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            inst_q  <= inst;
            trap_pc <= pc;
        end
        if (state == S_EXEC && is_ebreak) begin
            result <= rf_rdata1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        fetch_en |-> (fetch_addr >> 2) < cpu_pkg::word_t'(MEM_WORDS));

    assert property (@(posedge clk) disable iff (rst)
        !(dmem.r_en && dmem.w_en));

endmodule

// ==== core/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  cpu_pkg::inst_t   inst,
    output cpu_pkg::alu_op_e alu_op,
    output cpu_pkg::word_t   imm,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output logic [4:0]       rd,
    output logic             use_imm,
    output logic             reg_we,
    output logic             is_load,
    output logic             is_store,
    output cpu_pkg::mask_t   store_mask,
    output logic             is_branch,
    output logic             branch_ne,
    output logic             is_jal,
    output logic             is_ebreak,
    output logic             illegal
);

    // EBREAK reports a0, so its first read port is pointed there.
    localparam logic [4:0] A0_REG = 5'd10;

    always_comb begin
        alu_op     = cpu_pkg::ALU_ADD;
        imm        = '0;
        rs1        = inst.r.rs1;
        rs2        = inst.r.rs2;
        rd         = inst.r.rd;
        use_imm    = 1'b0;
        reg_we     = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        store_mask = '0;
        is_branch  = 1'b0;
        branch_ne  = 1'b0;
        is_jal     = 1'b0;
        is_ebreak  = 1'b0;
        illegal    = 1'b0;

        case (inst.r.opcode)
            cpu_pkg::OPC_LUI: begin
                alu_op  = cpu_pkg::ALU_PASS_B;
                imm     = {inst.u.imm_31_12, 12'b0};
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            cpu_pkg::OPC_OP_IMM: begin
                imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
                use_imm = 1'b1;
                reg_we  = 1'b1;
                case (inst.i.funct3)
                    3'b000:  alu_op = cpu_pkg::ALU_ADD;
                    3'b100:  alu_op = cpu_pkg::ALU_XOR;
                    3'b110:  alu_op = cpu_pkg::ALU_OR;
                    3'b111:  alu_op = cpu_pkg::ALU_AND;
                    default: illegal = 1'b1;
                endcase
            end
            cpu_pkg::OPC_OP: begin
                reg_we = 1'b1;
                case ({inst.r.funct7, inst.r.funct3})
                    {7'b0000000, 3'b000}: alu_op = cpu_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op = cpu_pkg::ALU_SUB;
                    {7'b0000000, 3'b100}: alu_op = cpu_pkg::ALU_XOR;
                    {7'b0000000, 3'b110}: alu_op = cpu_pkg::ALU_OR;
                    {7'b0000000, 3'b111}: alu_op = cpu_pkg::ALU_AND;
                    default:              illegal = 1'b1;
                endcase
            end
            cpu_pkg::OPC_LOAD: begin
                imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
                use_imm = 1'b1;
                reg_we  = 1'b1;
                is_load = 1'b1;
                illegal = (inst.i.funct3 != 3'b010);
            end
            cpu_pkg::OPC_STORE: begin
                imm      = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
                use_imm  = 1'b1;
                is_store = 1'b1;
                case (inst.s.funct3)
                    3'b000:  store_mask = 4'b0001;
                    3'b010:  store_mask = 4'b1111;
                    default: illegal = 1'b1;
                endcase
            end
            cpu_pkg::OPC_BRANCH: begin
                imm       = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                             inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
                is_branch = 1'b1;
                branch_ne = inst.b.funct3[0];
                illegal   = (inst.b.funct3[2:1] != 2'b00);
            end
            cpu_pkg::OPC_JAL: begin
                imm    = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                          inst.j.imm_11, inst.j.imm_10_1, 1'b0};
                reg_we = 1'b1;
                is_jal = 1'b1;
            end
            cpu_pkg::OPC_SYSTEM: begin
                is_ebreak = (inst == cpu_pkg::EBREAK_WORD);
                illegal   = !is_ebreak;
                rs1       = A0_REG;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== core/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic           clk,
    input  logic           rst,
    input  logic [4:0]     rs1,
    input  logic [4:0]     rs2,
    input  logic [4:0]     rd,
    input  logic           we,
    input  cpu_pkg::word_t wdata,
    output cpu_pkg::word_t rdata1,
    output cpu_pkg::word_t rdata2
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero.
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 run,
    input  cpu_pkg::word_t       paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  cpu_pkg::word_t       pwdata,
    output cpu_pkg::word_t       prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 halted,
    output logic                 trap,
    output cpu_pkg::trap_cause_e trap_cause,
    output cpu_pkg::word_t       trap_pc,
    output cpu_pkg::word_t       result
);

    cpu_pkg::word_t fetch_addr;
    cpu_pkg::word_t fetch_data;
    logic           fetch_en;

    dmem_if dmem ();

    cpu_core #(
        .MEM_WORDS(MEM_WORDS)
    ) u_core (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .fetch_data(fetch_data),
        .fetch_addr(fetch_addr),
        .fetch_en  (fetch_en),
        .halted    (halted),
        .trap      (trap),
        .trap_cause(trap_cause),
        .trap_pc   (trap_pc),
        .result    (result),
        .dmem      (dmem.core)
    );

    mem_ctrl #(
        .MEM_WORDS(MEM_WORDS)
    ) u_mem_ctrl (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .fetch_addr(fetch_addr),
        .fetch_en  (fetch_en),
        .fetch_data(fetch_data),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .dmem      (dmem.mem)
    );

endmodule

// ==== logic/mem_ctrl.sv ====
`timescale 1ns/100ps

module mem_ctrl #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           run,
    input  cpu_pkg::word_t fetch_addr,
    input  logic           fetch_en,
    output cpu_pkg::word_t fetch_data,
    input  cpu_pkg::word_t paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  cpu_pkg::word_t pwdata,
    output cpu_pkg::word_t prdata,
    output logic           pready,
    output logic           pslverr,
    dmem_if.mem            dmem
);

    localparam int AW    = $clog2(MEM_WORDS);
    localparam int LANES = $bits(cpu_pkg::mask_t);

    cpu_pkg::word_t mem [MEM_WORDS];
    cpu_pkg::word_t apb_rdata_q;

    logic [AW-1:0] fetch_idx;
    logic [AW-1:0] data_idx;
    logic [AW-1:0] apb_idx;
    logic          apb_access;
    logic          apb_wr;

    // Addresses are byte addresses; the two low bits select a lane.
    assign fetch_idx = fetch_addr[AW+1:2];
    assign data_idx  = dmem.addr[AW+1:2];
    assign apb_idx   = paddr[AW+1:2];

    // --------------------------------------------------
    // APB host port
    // --------------------------------------------------
    assign apb_access = psel && penable;
    assign apb_wr     = apb_access && pwrite && !run;

    assign pready  = 1'b1;
    assign pslverr = apb_access && run;
    assign prdata  = apb_rdata_q;

    // --------------------------------------------------
    // Memory array
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (dmem.w_en) begin
            for (int i = 0; i < LANES; i++) begin
                if (dmem.mask[i]) begin
                    mem[data_idx][8*i +: 8] <= dmem.wdata[8*i +: 8];
                end
            end
        end else if (apb_wr) begin
            mem[apb_idx] <= pwdata;
        end

        if (fetch_en) begin
            fetch_data <= mem[fetch_idx];
        end
        if (dmem.r_en) begin
            dmem.rdata <= mem[data_idx];
        end
        // The read word is captured during the setup phase.
        if (psel && !penable) begin
            apb_rdata_q <= mem[apb_idx];
        end
    end

    // The core only writes while run is high and the host only while it is low.
    assert property (@(posedge clk) disable iff (rst)
        !(dmem.w_en && apb_wr));

endmodule

// ==== project.f ====
common/cpu_pkg.sv
common/dmem_if.sv
core/alu.sv
core/reg_file.sv
core/inst_decoder.sv
core/cpu_core.sv
logic/mem_ctrl.sv
logic/cpu_top.sv
tests/tb_cpu.sv

// ==== tests/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu;

    localparam int NUM_TESTS = 8;
    localparam int MAX_WORDS = 8;
    localparam cpu_pkg::word_t EBREAK = 32'h0010_0073;

    logic                 clk;
    logic                 rst;
    logic                 run;
    cpu_pkg::word_t       paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    cpu_pkg::word_t       pwdata;
    cpu_pkg::word_t       prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 halted;
    logic                 trap;
    cpu_pkg::trap_cause_e trap_cause;
    cpu_pkg::word_t       trap_pc;
    cpu_pkg::word_t       result;

    // The test table keeps one index per entry.
    string                t_name   [NUM_TESTS];
    cpu_pkg::word_t       t_prog   [NUM_TESTS][MAX_WORDS];
    int                   t_len    [NUM_TESTS];
    cpu_pkg::word_t       t_result [NUM_TESTS];
    cpu_pkg::trap_cause_e t_cause  [NUM_TESTS];
    cpu_pkg::word_t       t_pc     [NUM_TESTS];
    cpu_pkg::word_t       t_addr   [NUM_TESTS];
    cpu_pkg::word_t       t_init   [NUM_TESTS];
    cpu_pkg::word_t       t_word   [NUM_TESTS];
    logic                 t_probe  [NUM_TESTS];

    int checks = 0;
    int errors = 0;
    int cycles = 0;
    int cycle_limit = 0;

    cpu_top #(
        .MEM_WORDS(256)
    ) UUT (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .halted    (halted),
        .trap      (trap),
        .trap_cause(trap_cause),
        .trap_pc   (trap_pc),
        .result    (result)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("The run reached its limit of %0d cycles before all tests finished.",
                     cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // RV32I instruction encoders
    // --------------------------------------------------
    function automatic cpu_pkg::word_t lui_insn(input int rd, input int upper);
        return {upper[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic cpu_pkg::word_t addi_insn(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic cpu_pkg::word_t rr_insn(input logic [6:0] funct7, input logic [2:0] funct3,
                                               input int rd, input int rs1, input int rs2);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
    endfunction

    function automatic cpu_pkg::word_t lw_insn(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic cpu_pkg::word_t store_insn(input logic [2:0] funct3, input int rs2,
                                                  input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], funct3, imm[4:0], 7'b0100011};
    endfunction

    function automatic cpu_pkg::word_t branch_insn(input logic [2:0] funct3, input int rs1,
                                                   input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic cpu_pkg::word_t jal_insn(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // --------------------------------------------------
    // Table construction
    // --------------------------------------------------
    task automatic add_insn(input int idx, input cpu_pkg::word_t w);
        t_prog[idx][t_len[idx]] = w;
        t_len[idx]++;
    endtask

    task automatic set_expect(input int idx, input string name, input cpu_pkg::word_t res,
                              input cpu_pkg::trap_cause_e cause, input cpu_pkg::word_t pc);
        t_name[idx]   = name;
        t_result[idx] = res;
        t_cause[idx]  = cause;
        t_pc[idx]     = pc;
    endtask

    task automatic set_check(input int idx, input cpu_pkg::word_t addr, input cpu_pkg::word_t init,
                             input cpu_pkg::word_t word, input logic probe);
        t_addr[idx]  = addr;
        t_init[idx]  = init;
        t_word[idx]  = word;
        t_probe[idx] = probe;
    endtask

    task automatic build_table();
        cpu_pkg::word_t r1;
        cpu_pkg::word_t r2;
        cpu_pkg::word_t r3;
        cpu_pkg::word_t w;
        logic [7:0]     b;
        for (int n = 0; n < NUM_TESTS; n++) begin
            t_len[n] = 0;
            for (int k = 0; k < MAX_WORDS; k++) begin
                t_prog[n][k] = '0;
            end
        end

        r1 = 32'h1234_5000 + 32'h0000_0678;
        r2 = 32'hFFFF_FFF0;
        r3 = r1 + r2;
        add_insn(0, lui_insn(1, 'h12345));
        add_insn(0, addi_insn(1, 1, 'h678));
        add_insn(0, addi_insn(2, 0, -16));
        add_insn(0, rr_insn(7'b0000000, 3'b000, 3, 1, 2));
        add_insn(0, rr_insn(7'b0100000, 3'b000, 10, 2, 3));
        add_insn(0, EBREAK);
        set_expect(0, "add_sub", r2 - r3, cpu_pkg::TRAP_NONE, '0);
        w = $urandom;
        set_check(0, 32'h80, w, w, 1'b0);

        r1 = 32'h0000_05A5;
        r2 = 32'hF0F0_F000 + 32'hFFFF_FFFF;
        add_insn(1, addi_insn(1, 0, 'h5A5));
        add_insn(1, lui_insn(2, 'hF0F0F));
        add_insn(1, addi_insn(2, 2, -1));
        add_insn(1, rr_insn(7'b0000000, 3'b111, 3, 1, 2));
        add_insn(1, rr_insn(7'b0000000, 3'b110, 4, 1, 2));
        add_insn(1, rr_insn(7'b0000000, 3'b100, 10, 3, 4));
        add_insn(1, EBREAK);
        set_expect(1, "logic_ops", (r1 & r2) ^ (r1 | r2), cpu_pkg::TRAP_NONE, '0);
        w = $urandom;
        set_check(1, 32'h84, w, w, 1'b0);

        // LUI takes the rounded upper part so that ADDI's sign extension cancels out.
        w = $urandom;
        add_insn(2, lui_insn(1, int'((w + 32'h800) >> 12)));
        add_insn(2, addi_insn(1, 1, int'(w[11:0])));
        add_insn(2, store_insn(3'b010, 1, 0, 'h80));
        add_insn(2, lw_insn(10, 0, 'h80));
        add_insn(2, EBREAK);
        set_expect(2, "sw_lw", w, cpu_pkg::TRAP_NONE, '0);
        set_check(2, 32'h80, ~w, w, 1'b0);

        w = $urandom;
        b = 8'($urandom);
        add_insn(3, addi_insn(1, 0, int'(b)));
        add_insn(3, store_insn(3'b000, 1, 0, 'h86));
        add_insn(3, lw_insn(10, 0, 'h84));
        add_insn(3, EBREAK);
        set_expect(3, "sb_lane", {w[31:24], b, w[15:0]}, cpu_pkg::TRAP_NONE, '0);
        set_check(3, 32'h84, w, {w[31:24], b, w[15:0]}, 1'b0);

        add_insn(4, addi_insn(1, 0, 5));
        add_insn(4, addi_insn(10, 0, 0));
        add_insn(4, addi_insn(10, 10, 1));
        add_insn(4, addi_insn(1, 1, -1));
        add_insn(4, branch_insn(3'b001, 1, 0, -8));
        add_insn(4, jal_insn(0, 8));
        add_insn(4, addi_insn(10, 10, 100));
        add_insn(4, EBREAK);
        set_expect(4, "bne_jal", 32'd5, cpu_pkg::TRAP_NONE, '0);
        w = $urandom;
        set_check(4, 32'h88, w, w, 1'b0);

        add_insn(5, addi_insn(10, 0, 1));
        add_insn(5, 32'h0000_0000);
        add_insn(5, EBREAK);
        set_expect(5, "illegal", '0, cpu_pkg::TRAP_ILLEGAL, 32'd4);
        w = $urandom;
        set_check(5, 32'h8C, w, w, 1'b0);

        add_insn(6, addi_insn(1, 0, 'h80));
        add_insn(6, lw_insn(10, 1, 2));
        add_insn(6, EBREAK);
        set_expect(6, "lw_misaligned", '0, cpu_pkg::TRAP_MISALIGNED_LS, 32'd4);
        w = $urandom;
        set_check(6, 32'h90, w, w, 1'b0);

        add_insn(7, addi_insn(10, 0, 'h2A));
        add_insn(7, EBREAK);
        set_expect(7, "apb_protect", 32'h2A, cpu_pkg::TRAP_NONE, '0);
        w = $urandom;
        set_check(7, 32'h94, w, w, 1'b1);
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input string what, input cpu_pkg::word_t exp,
                              input cpu_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_cause(input string name, input cpu_pkg::trap_cause_e exp,
                               input cpu_pkg::trap_cause_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s trap_cause: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    // --------------------------------------------------
    // APB host and run control
    // --------------------------------------------------
    task automatic apb_xfer(input logic write, input cpu_pkg::word_t addr,
                            input cpu_pkg::word_t wdata, output cpu_pkg::word_t rdata,
                            output logic err, output logic ready);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        ready = pready;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic wait_for_stop();
        do begin
            @(negedge clk);
        end while (!(halted || trap));
    endtask

    task automatic run_entry(input int i);
        cpu_pkg::word_t rd_word;
        logic           err;
        logic           rdy;
        for (int k = 0; k < t_len[i]; k++) begin
            apb_xfer(1'b1, cpu_pkg::word_t'(4 * k), t_prog[i][k], rd_word, err, rdy);
            check_bit(t_name[i], "pslverr on program load", 1'b0, err);
        end
        apb_xfer(1'b1, t_addr[i], t_init[i], rd_word, err, rdy);
        check_bit(t_name[i], "pslverr on data load", 1'b0, err);

        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        if (t_probe[i]) begin
            apb_xfer(1'b1, t_addr[i], ~t_init[i], rd_word, err, rdy);
            check_bit(t_name[i], "pslverr while running", 1'b1, err);
        end
        wait_for_stop();

        check_bit(t_name[i], "halted", t_cause[i] == cpu_pkg::TRAP_NONE, halted);
        check_bit(t_name[i], "trap", t_cause[i] != cpu_pkg::TRAP_NONE, trap);
        check_cause(t_name[i], t_cause[i], trap_cause);
        if (t_cause[i] == cpu_pkg::TRAP_NONE) begin
            check_word(t_name[i], "result", t_result[i], result);
        end else begin
            check_word(t_name[i], "trap_pc", t_pc[i], trap_pc);
        end

        @(posedge clk);
        run <= 1'b0;
        apb_xfer(1'b0, t_addr[i], '0, rd_word, err, rdy);
        check_bit(t_name[i], "pready", 1'b1, rdy);
        check_word(t_name[i], "memory word", t_word[i], rd_word);
    endtask

    initial begin
        int loaded;
        clk     = 1'b0;
        rst     = 1'b1;
        run     = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        void'($urandom(96814));
        build_table();

        loaded = 0;
        for (int n = 0; n < NUM_TESTS; n++) begin
            loaded += t_len[n] + 1;
        end
        cycle_limit = NUM_TESTS * 300 + 20 * loaded;

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_entry(i);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
